// File: source/display_config.svh
`ifndef DISPLAY_CONFIG_SVH
`define DISPLAY_CONFIG_SVH

// memory sizes in bytes
`define MAIN_MEMORY_BYTES 1024
`define IO_REGISTERS_BYTES 4096

// screen geometry
`define RESOLUTION_X 400
`define RESOLUTION_Y 300

// palette
`define PALETTE_LENGTH 256
`define COLOR_BITS 12

// region bases on the data bus
`define MAIN_BASE 32'h0000_0000
`define IO_BASE 32'h0001_0000
`define DRAW_BASE 32'h0002_0000
`define PALETTE_BASE 32'h0003_0000
// framebuffer window runs past 0x4ffff, last region on the bus
`define FB_BASE 32'h0004_0000

`endif

// File: source/display_pkg.sv
`include "display_config.svh"

package display_pkg;

    // data bus
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_en_t;

    // local address spaces
    typedef logic [$clog2(`MAIN_MEMORY_BYTES)-1:0] mem_addr_t;
    typedef logic [$clog2(`IO_REGISTERS_BYTES)-1:0] io_addr_t;
    typedef logic [$clog2(`RESOLUTION_X*`RESOLUTION_Y)-1:0] pixel_addr_t;

    // colours
    typedef logic [$clog2(`PALETTE_LENGTH)-1:0] color_index_t;
    typedef logic [`COLOR_BITS-1:0] color_t;

    // drawing geometry
    typedef logic [$clog2(`RESOLUTION_X)-1:0] coord_x_t;
    typedef logic [$clog2(`RESOLUTION_Y)-1:0] coord_y_t;
    typedef logic [$clog2(`RESOLUTION_X)-1:0] span_len_t;

    typedef enum logic [2:0] {
        MAIN,
        IO,
        DRAW,
        PALETTE,
        FB,
        NONE
    } region_t;

    typedef enum logic {
        IDLE,
        RUN
    } span_state_t;

endpackage

// File: source/memory_mapper.sv
`timescale 1ns/1ps
`include "display_config.svh"

module memory_mapper (
    input logic clk,
    input logic reset,
    // data bus
    input display_pkg::bus_addr_t bus_addr,
    input display_pkg::word_t bus_wr_data,
    input display_pkg::byte_en_t bus_wr_en,
    output display_pkg::word_t bus_rd_data,
    // main memory
    output display_pkg::mem_addr_t mem_addr,
    output display_pkg::word_t mem_wr_data,
    output display_pkg::byte_en_t mem_wr_en,
    input display_pkg::word_t mem_rd_data,
    // external i/o registers
    output display_pkg::io_addr_t io_reg_addr,
    output display_pkg::word_t io_reg_wr_data,
    output display_pkg::byte_en_t io_reg_wr_en,
    input display_pkg::word_t io_reg_rd_data,
    // drawing registers
    output logic [4:0] draw_addr,
    output display_pkg::word_t draw_wr_data,
    output logic draw_wr,
    input display_pkg::word_t draw_rd_data,
    // palette port
    output display_pkg::color_index_t palette_wr_index,
    output display_pkg::color_t palette_wr_color,
    output logic palette_wr_en,
    // framebuffer port
    output display_pkg::pixel_addr_t fb_bus_addr,
    output display_pkg::color_index_t fb_bus_data,
    output logic fb_bus_wr
);
    import display_pkg::*;

    localparam int unsigned DRAW_BYTES = 32;
    localparam int unsigned PALETTE_BYTES = 2 * `PALETTE_LENGTH;
    localparam int unsigned FB_BYTES = `RESOLUTION_X * `RESOLUTION_Y;

    region_t region;
    region_t region_q;
    bus_addr_t base;
    bus_addr_t offset;
    word_t io_rd_q;
    // one bit per window, main memory in bit 0
    logic [4:0] window_hit;

    // wraps below base, so one compare covers both bounds
    function automatic logic in_window(input bus_addr_t addr, input bus_addr_t win_base,
                                       input int unsigned win_bytes);
        return (addr - win_base) < win_bytes;
    endfunction

    always_comb begin
        window_hit[0] = in_window(bus_addr, `MAIN_BASE, `MAIN_MEMORY_BYTES);
        window_hit[1] = in_window(bus_addr, `IO_BASE, `IO_REGISTERS_BYTES);
        window_hit[2] = in_window(bus_addr, `DRAW_BASE, DRAW_BYTES);
        window_hit[3] = in_window(bus_addr, `PALETTE_BASE, PALETTE_BYTES);
        window_hit[4] = in_window(bus_addr, `FB_BASE, FB_BYTES);
        region = NONE;
        base = '0;
        if (window_hit[0]) begin
            region = MAIN;
            base = `MAIN_BASE;
        end else if (window_hit[1]) begin
            region = IO;
            base = `IO_BASE;
        end else if (window_hit[2]) begin
            region = DRAW;
            base = `DRAW_BASE;
        end else if (window_hit[3]) begin
            region = PALETTE;
            base = `PALETTE_BASE;
        end else if (window_hit[4]) begin
            region = FB;
            base = `FB_BASE;
        end
        offset = bus_addr - base;
    end

    // addresses and data fan out, strobes only to the hit region
    always_comb begin
        mem_addr = mem_addr_t'(offset);
        mem_wr_data = bus_wr_data;
        mem_wr_en = (region == MAIN) ? bus_wr_en : '0;

        io_reg_addr = io_addr_t'(offset);
        io_reg_wr_data = bus_wr_data;
        io_reg_wr_en = (region == IO) ? bus_wr_en : '0;

        draw_addr = offset[4:0];
        draw_wr_data = bus_wr_data;
        draw_wr = (region == DRAW) && (bus_wr_en != '0);

        palette_wr_index = color_index_t'(offset >> 1);
        palette_wr_color = bus_wr_data[`COLOR_BITS-1:0];
        palette_wr_en = (region == PALETTE) && (bus_wr_en != '0);

        fb_bus_addr = pixel_addr_t'(offset);
        fb_bus_data = bus_wr_data[7:0];
        fb_bus_wr = (region == FB) && (bus_wr_en != '0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            region_q <= NONE;
            io_rd_q <= '0;
        end else begin
            region_q <= region;
            io_rd_q <= io_reg_rd_data;
        end
    end

    // palette and framebuffer are write only
    always_comb begin
        case (region_q)
            MAIN: bus_rd_data = mem_rd_data;
            IO: bus_rd_data = io_rd_q;
            DRAW: bus_rd_data = draw_rd_data;
            default: bus_rd_data = '0;
        endcase
    end

    a_one_write_region: assert property (@(posedge clk) disable iff (reset)
        (bus_wr_en != '0) |-> $onehot0(window_hit))
        else $error("memory_mapper: write address falls in more than one region window");

endmodule

// File: source/main_memory.sv
`timescale 1ns/1ps
`include "display_config.svh"

module main_memory (
    input logic clk,
    input logic reset,
    input display_pkg::mem_addr_t addr,
    input display_pkg::word_t wr_data,
    input display_pkg::byte_en_t wr_en,
    output display_pkg::word_t rd_data
);
    import display_pkg::*;

    localparam int WORDS = `MAIN_MEMORY_BYTES / 4;

    word_t mem [WORDS];
    logic [$clog2(WORDS)-1:0] word_sel;

    // byte offset within the word is dropped
    assign word_sel = addr[$bits(mem_addr_t)-1:2];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wr_en[lane]) begin
                mem[word_sel][lane*8 +: 8] <= wr_data[lane*8 +: 8];
            end
        end
    end

    // read returns the word before a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[word_sel];
        end
    end

endmodule

// File: source/draw_registers.sv
`timescale 1ns/1ps

module draw_registers (
    input logic clk,
    input logic reset,
    input logic [4:0] addr,
    input display_pkg::word_t wr_data,
    input logic wr,
    output display_pkg::word_t rd_data,
    input logic busy,
    output display_pkg::coord_x_t pos_x,
    output display_pkg::coord_y_t pos_y,
    output display_pkg::color_index_t color_index,
    output display_pkg::span_len_t span_len,
    output logic span_start
);
    import display_pkg::*;

    localparam logic [4:0] POS_X_OFFSET = 5'h00;
    localparam logic [4:0] POS_Y_OFFSET = 5'h04;
    localparam logic [4:0] COLOR_OFFSET = 5'h08;
    localparam logic [4:0] SPAN_OFFSET = 5'h0c;
    localparam logic [4:0] STATUS_OFFSET = 5'h10;

    word_t rd_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            pos_x <= '0;
            pos_y <= '0;
            color_index <= '0;
            span_len <= '0;
            span_start <= 1'b0;
        end else begin
            span_start <= 1'b0;
            if (wr) begin
                case (addr)
                    POS_X_OFFSET: pos_x <= coord_x_t'(wr_data);
                    POS_Y_OFFSET: pos_y <= coord_y_t'(wr_data);
                    COLOR_OFFSET: color_index <= color_index_t'(wr_data);
                    SPAN_OFFSET: begin
                        span_len <= span_len_t'(wr_data);
                        // zero length is stored but starts nothing
                        span_start <= (span_len_t'(wr_data) != '0);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        rd_next = '0;
        case (addr)
            POS_X_OFFSET: rd_next = word_t'(pos_x);
            POS_Y_OFFSET: rd_next = word_t'(pos_y);
            COLOR_OFFSET: rd_next = word_t'(color_index);
            // pending start counts as busy so a poll right after the write sees it
            STATUS_OFFSET: rd_next[0] = busy | span_start;
            default: rd_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_next;
        end
    end

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        span_start |-> !busy)
        else $error("draw_registers: span started while the span writer is busy");

endmodule

// File: source/span_writer.sv
`timescale 1ns/1ps
`include "display_config.svh"

module span_writer (
    input logic clk,
    input logic reset,
    input display_pkg::coord_x_t pos_x,
    input display_pkg::coord_y_t pos_y,
    input display_pkg::color_index_t color_index,
    input display_pkg::span_len_t span_len,
    input logic span_start,
    input display_pkg::pixel_addr_t fb_bus_addr,
    input display_pkg::color_index_t fb_bus_data,
    input logic fb_bus_wr,
    output logic busy,
    output display_pkg::pixel_addr_t fb_addr,
    output display_pkg::color_index_t fb_wr_data,
    output logic fb_wr_en
);
    import display_pkg::*;

    span_state_t state;
    pixel_addr_t pixel;
    span_len_t remaining;
    color_index_t fill_index;
    pixel_addr_t start_pixel;
    span_len_t room;
    span_len_t count;

    // start pixel and row-end clipping
    always_comb begin
        start_pixel = pixel_addr_t'(pos_y) * pixel_addr_t'(`RESOLUTION_X)
                      + pixel_addr_t'(pos_x);
        if (pos_x < coord_x_t'(`RESOLUTION_X) && pos_y < coord_y_t'(`RESOLUTION_Y)) begin
            room = span_len_t'(`RESOLUTION_X) - span_len_t'(pos_x);
        end else begin
            room = '0;
        end
        count = (span_len < room) ? span_len : room;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pixel <= '0;
            remaining <= '0;
            fill_index <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (span_start && count != '0) begin
                        pixel <= start_pixel;
                        remaining <= count;
                        fill_index <= color_index;
                        state <= RUN;
                    end
                end
                RUN: begin
                    pixel <= pixel + pixel_addr_t'(1);
                    remaining <= remaining - span_len_t'(1);
                    if (remaining == span_len_t'(1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // bus writes pass straight through when idle
    always_comb begin
        busy = (state == RUN);
        if (state == RUN) begin
            fb_addr = pixel;
            fb_wr_data = fill_index;
            fb_wr_en = 1'b1;
        end else begin
            fb_addr = fb_bus_addr;
            fb_wr_data = fb_bus_data;
            fb_wr_en = fb_bus_wr;
        end
    end

    a_fb_in_range: assert property (@(posedge clk) disable iff (reset)
        fb_wr_en |-> (32'(fb_addr) < `RESOLUTION_X * `RESOLUTION_Y))
        else $error("span_writer: fb_addr 0x%h beyond the screen", fb_addr);

    a_no_bus_write_while_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !fb_bus_wr)
        else $error("span_writer: software wrote the framebuffer during a span");

endmodule

// File: source/display_processor.sv
`timescale 1ns/1ps

module display_processor (
    input logic clk,
    input logic reset,
    // data bus
    input display_pkg::bus_addr_t bus_addr,
    input display_pkg::word_t bus_wr_data,
    input display_pkg::byte_en_t bus_wr_en,
    output display_pkg::word_t bus_rd_data,
    // memory mapped i/o
    output display_pkg::io_addr_t io_reg_addr,
    output display_pkg::word_t io_reg_wr_data,
    output display_pkg::byte_en_t io_reg_wr_en,
    input display_pkg::word_t io_reg_rd_data,
    // colour palette
    output display_pkg::color_index_t palette_wr_index,
    output display_pkg::color_t palette_wr_color,
    output logic palette_wr_en,
    // framebuffer
    output display_pkg::pixel_addr_t fb_addr,
    output display_pkg::color_index_t fb_wr_data,
    output logic fb_wr_en
);
    import display_pkg::*;

    mem_addr_t mem_addr;
    word_t mem_wr_data;
    byte_en_t mem_wr_en;
    word_t mem_rd_data;

    logic [4:0] draw_addr;
    word_t draw_wr_data;
    logic draw_wr;
    word_t draw_rd_data;

    pixel_addr_t fb_bus_addr;
    color_index_t fb_bus_data;
    logic fb_bus_wr;

    coord_x_t pos_x;
    coord_y_t pos_y;
    color_index_t color_index;
    span_len_t span_len;
    logic span_start;
    logic busy;

    memory_mapper u_memory_mapper (
        .clk              (clk),
        .reset            (reset),
        .bus_addr         (bus_addr),
        .bus_wr_data      (bus_wr_data),
        .bus_wr_en        (bus_wr_en),
        .bus_rd_data      (bus_rd_data),
        .mem_addr         (mem_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_en        (mem_wr_en),
        .mem_rd_data      (mem_rd_data),
        .io_reg_addr      (io_reg_addr),
        .io_reg_wr_data   (io_reg_wr_data),
        .io_reg_wr_en     (io_reg_wr_en),
        .io_reg_rd_data   (io_reg_rd_data),
        .draw_addr        (draw_addr),
        .draw_wr_data     (draw_wr_data),
        .draw_wr          (draw_wr),
        .draw_rd_data     (draw_rd_data),
        .palette_wr_index (palette_wr_index),
        .palette_wr_color (palette_wr_color),
        .palette_wr_en    (palette_wr_en),
        .fb_bus_addr      (fb_bus_addr),
        .fb_bus_data      (fb_bus_data),
        .fb_bus_wr        (fb_bus_wr)
    );

    main_memory u_main_memory (
        .clk     (clk),
        .reset   (reset),
        .addr    (mem_addr),
        .wr_data (mem_wr_data),
        .wr_en   (mem_wr_en),
        .rd_data (mem_rd_data)
    );

    draw_registers u_draw_registers (
        .clk         (clk),
        .reset       (reset),
        .addr        (draw_addr),
        .wr_data     (draw_wr_data),
        .wr          (draw_wr),
        .rd_data     (draw_rd_data),
        .busy        (busy),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .color_index (color_index),
        .span_len    (span_len),
        .span_start  (span_start)
    );

    span_writer u_span_writer (
        .clk         (clk),
        .reset       (reset),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .color_index (color_index),
        .span_len    (span_len),
        .span_start  (span_start),
        .fb_bus_addr (fb_bus_addr),
        .fb_bus_data (fb_bus_data),
        .fb_bus_wr   (fb_bus_wr),
        .busy        (busy),
        .fb_addr     (fb_addr),
        .fb_wr_data  (fb_wr_data),
        .fb_wr_en    (fb_wr_en)
    );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous reset, held over two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: bench/display_processor_tb.sv
`timescale 1ns/1ps
`include "display_config.svh"

module display_processor_tb;
    import display_pkg::*;

    localparam int MEM_WORDS = `MAIN_MEMORY_BYTES / 4;
    localparam int IO_WORDS = `IO_REGISTERS_BYTES / 4;
    localparam int SCREEN_PIXELS = `RESOLUTION_X * `RESOLUTION_Y;
    localparam int MEM_OPS = 64;
    localparam int IO_OPS = 64;
    localparam int PALETTE_OPS = 32;
    localparam int FB_OPS = 32;
    localparam int SPANS = 12;
    localparam bus_addr_t IDLE_ADDR = 32'h0009_0000;

    // a read costs two bus cycles, a span at most a full row of polls
    localparam int TEST_CYCLES = MEM_WORDS + 3 * MEM_OPS + 2 * IO_OPS + PALETTE_OPS + FB_OPS
                                 + SPANS * (`RESOLUTION_X + 8) + 24;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

    logic clk;
    logic reset;
    bus_addr_t bus_addr;
    word_t bus_wr_data;
    byte_en_t bus_wr_en;
    word_t bus_rd_data;
    io_addr_t io_reg_addr;
    word_t io_reg_wr_data;
    byte_en_t io_reg_wr_en;
    word_t io_reg_rd_data;
    color_index_t palette_wr_index;
    color_t palette_wr_color;
    logic palette_wr_en;
    pixel_addr_t fb_addr;
    color_index_t fb_wr_data;
    logic fb_wr_en;

    word_t mem_model [MEM_WORDS];
    word_t io_model [IO_WORDS];
    // {index, colour} and {pad, pixel, index} still to be seen on the ports
    logic [19:0] palette_expected [$];
    logic [31:0] fb_expected [$];

    integer seed;
    int errors;
    int tests_run;
    int tests_failed;
    int cycles = 0;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    display_processor u_display_processor (
        .clk              (clk),
        .reset            (reset),
        .bus_addr         (bus_addr),
        .bus_wr_data      (bus_wr_data),
        .bus_wr_en        (bus_wr_en),
        .bus_rd_data      (bus_rd_data),
        .io_reg_addr      (io_reg_addr),
        .io_reg_wr_data   (io_reg_wr_data),
        .io_reg_wr_en     (io_reg_wr_en),
        .io_reg_rd_data   (io_reg_rd_data),
        .palette_wr_index (palette_wr_index),
        .palette_wr_color (palette_wr_color),
        .palette_wr_en    (palette_wr_en),
        .fb_addr          (fb_addr),
        .fb_wr_data       (fb_wr_data),
        .fb_wr_en         (fb_wr_en)
    );

    // external i/o register file answers without a clock
    assign io_reg_rd_data = io_model[io_reg_addr[$bits(io_addr_t)-1:2]];

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input byte_en_t strobes);
        word_t result;
        result = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (strobes[lane]) begin
                result[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return result;
    endfunction

    // one bus cycle, returns at the falling edge where outputs have settled
    task automatic bus_access(input bus_addr_t addr, input word_t data, input byte_en_t strobes);
        @(posedge clk);
        bus_addr <= addr;
        bus_wr_data <= data;
        bus_wr_en <= strobes;
        @(negedge clk);
    endtask

    task automatic bus_read(input bus_addr_t addr, output word_t data);
        bus_access(addr, '0, '0);
        bus_access(IDLE_ADDR, '0, '0);
        data = bus_rd_data;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    always @(negedge clk) begin
        logic [31:0] entry;
        if (!reset && fb_wr_en) begin
            if (fb_expected.size() == 0) begin
                check_true(1'b0, $sformatf("unexpected framebuffer write at 0x%h", fb_addr));
            end else begin
                entry = fb_expected.pop_front();
                check_value("fb_addr", word_t'(fb_addr), word_t'(entry[24:8]));
                check_value("fb_wr_data", word_t'(fb_wr_data), word_t'(entry[7:0]));
            end
        end
    end

    always @(negedge clk) begin
        logic [19:0] entry;
        if (!reset && palette_wr_en) begin
            if (palette_expected.size() == 0) begin
                check_true(1'b0, "unexpected palette write");
            end else begin
                entry = palette_expected.pop_front();
                check_value("palette_wr_index", word_t'(palette_wr_index), word_t'(entry[19:12]));
                check_value("palette_wr_color", word_t'(palette_wr_color), word_t'(entry[11:0]));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic test_main_memory();
        int start_errors;
        int unsigned index;
        byte_en_t strobes;
        word_t data;
        word_t got;
        start_errors = errors;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = rand_word();
            bus_access(`MAIN_BASE + 32'(i * 4), mem_model[i], 4'hf);
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            index = rand_below(MEM_WORDS);
            strobes = byte_en_t'(rand_below(16));
            data = rand_word();
            mem_model[index] = merge_bytes(mem_model[index], data, strobes);
            bus_access(`MAIN_BASE + index * 4 + rand_below(4), data, strobes);
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            index = rand_below(MEM_WORDS);
            bus_read(`MAIN_BASE + index * 4 + rand_below(4), got);
            check_value("bus_rd_data", got, mem_model[index]);
        end
        report_test("main memory", start_errors);
    endtask

    task automatic test_io_registers();
        int start_errors;
        int unsigned offset;
        byte_en_t strobes;
        word_t data;
        word_t expected;
        start_errors = errors;
        for (int i = 0; i < IO_OPS; i++) begin
            offset = rand_below(`IO_REGISTERS_BYTES);
            data = rand_word();
            if (rand_below(2) == 0) begin
                strobes = byte_en_t'(rand_below(15) + 1);
                bus_access(`IO_BASE + offset, data, strobes);
                check_value("io_reg_addr", word_t'(io_reg_addr), word_t'(offset));
                check_value("io_reg_wr_data", io_reg_wr_data, data);
                check_value("io_reg_wr_en", word_t'(io_reg_wr_en), word_t'(strobes));
                io_model[offset / 4] = merge_bytes(io_model[offset / 4], data, strobes);
            end else begin
                expected = io_model[offset / 4];
                bus_access(`IO_BASE + offset, '0, '0);
                check_value("io_reg_addr", word_t'(io_reg_addr), word_t'(offset));
                check_value("io_reg_wr_en", word_t'(io_reg_wr_en), '0);
                bus_access(IDLE_ADDR, '0, '0);
                check_value("bus_rd_data", bus_rd_data, expected);
            end
        end
        report_test("io registers", start_errors);
    endtask

    task automatic test_palette();
        int start_errors;
        int unsigned offset;
        word_t data;
        start_errors = errors;
        for (int i = 0; i < PALETTE_OPS; i++) begin
            offset = rand_below(2 * `PALETTE_LENGTH);
            data = rand_word();
            palette_expected.push_back({color_index_t'(offset / 2), data[`COLOR_BITS-1:0]});
            bus_access(`PALETTE_BASE + offset, data, byte_en_t'(rand_below(15) + 1));
        end
        bus_access(IDLE_ADDR, '0, '0);
        check_true(palette_expected.size() == 0, "palette writes missing on the port");
        report_test("palette", start_errors);
    endtask

    task automatic test_framebuffer_direct();
        int start_errors;
        int unsigned offset;
        word_t data;
        start_errors = errors;
        for (int i = 0; i < FB_OPS; i++) begin
            offset = rand_below(SCREEN_PIXELS);
            data = rand_word();
            fb_expected.push_back({7'b0, pixel_addr_t'(offset), data[7:0]});
            bus_access(`FB_BASE + offset, data, byte_en_t'(rand_below(15) + 1));
        end
        bus_access(IDLE_ADDR, '0, '0);
        check_true(fb_expected.size() == 0, "direct framebuffer writes missing on the port");
        report_test("framebuffer direct", start_errors);
    endtask

    task automatic test_spans();
        int start_errors;
        int unsigned x;
        int unsigned y;
        int unsigned len;
        int unsigned color;
        int unsigned count;
        int unsigned polls;
        logic busy_bit;
        word_t got;
        start_errors = errors;
        for (int i = 0; i < SPANS; i++) begin
            x = rand_below(`RESOLUTION_X);
            y = rand_below(`RESOLUTION_Y);
            len = rand_below(511) + 1;
            color = rand_below(`PALETTE_LENGTH);
            // first few start near the row end so they clip
            if (i < 4) begin
                x = `RESOLUTION_X - 1 - rand_below(16);
            end
            count = (len < `RESOLUTION_X - x) ? len : `RESOLUTION_X - x;
            bus_access(`DRAW_BASE + 32'h0, word_t'(x), 4'hf);
            bus_access(`DRAW_BASE + 32'h4, word_t'(y), 4'hf);
            bus_access(`DRAW_BASE + 32'h8, word_t'(color), 4'hf);
            for (int unsigned p = 0; p < count; p++) begin
                fb_expected.push_back({7'b0, pixel_addr_t'(y * `RESOLUTION_X + x + p),
                                       color_index_t'(color)});
            end
            bus_access(`DRAW_BASE + 32'hc, word_t'(len), 4'hf);
            polls = 0;
            busy_bit = 1'b1;
            while (busy_bit) begin
                bus_read(`DRAW_BASE + 32'h10, got);
                if (polls == 0) begin
                    check_true(got[0], "busy low right after the span start");
                end
                polls++;
                busy_bit = (got[0] === 1'b1);
            end
            check_true(fb_expected.size() == 0, "busy fell before the span was written");
            // busy covers count cycles, polled every other cycle
            check_value("status polls", word_t'(polls), word_t'(count / 2 + 2));
        end
        report_test("spans", start_errors);
    endtask

    task automatic test_register_readback();
        int start_errors;
        word_t x;
        word_t y;
        word_t color;
        word_t got;
        start_errors = errors;
        x = rand_word();
        y = rand_word();
        color = rand_word();
        bus_access(`DRAW_BASE + 32'h0, x, 4'hf);
        bus_access(`DRAW_BASE + 32'h4, y, 4'hf);
        bus_access(`DRAW_BASE + 32'h8, color, 4'hf);
        bus_read(`DRAW_BASE + 32'h0, got);
        check_value("pos_x", got, word_t'(coord_x_t'(x)));
        bus_read(`DRAW_BASE + 32'h4, got);
        check_value("pos_y", got, word_t'(coord_y_t'(y)));
        bus_read(`DRAW_BASE + 32'h8, got);
        check_value("color_index", got, word_t'(color_index_t'(color)));
        bus_read(`DRAW_BASE + 32'h14, got);
        check_value("draw unknown offset", got, '0);
        bus_read(`PALETTE_BASE + rand_below(2 * `PALETTE_LENGTH), got);
        check_value("palette read", got, '0);
        bus_read(`FB_BASE + rand_below(SCREEN_PIXELS), got);
        check_value("framebuffer read", got, '0);
        bus_read(IDLE_ADDR, got);
        check_value("unmapped read", got, '0);
        report_test("register readback", start_errors);
    endtask

    initial begin
        seed = 32'h26dc_4b62;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        bus_addr = IDLE_ADDR;
        bus_wr_data = '0;
        bus_wr_en = '0;
        for (int i = 0; i < IO_WORDS; i++) begin
            io_model[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
        end
        while (reset !== 1'b0) begin
            @(negedge clk);
        end

        test_main_memory();
        test_io_registers();
        test_palette();
        test_framebuffer_direct();
        test_spans();
        test_register_readback();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/display_pkg.sv
source/memory_mapper.sv
source/main_memory.sv
source/draw_registers.sv
source/span_writer.sv
source/display_processor.sv
bench/clock_gen.sv
bench/display_processor_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

verilator --binary --assert -f verilog.f --top-module display_processor_tb \
    -o display_processor_sim \
    && ./obj_dir/display_processor_sim | tee /dev/stderr \
        | grep "Simulation finished: PASS" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
